//--- axil_pkg.sv
package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;
    } aw_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;                      // no strobes, full words only
    } w_t;

    typedef struct packed {
        logic  valid;
        resp_e resp;
    } b_t;

    typedef struct packed {
        logic        valid;
        logic [11:0] addr;
    } ar_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        resp_e       resp;
    } r_t;

    ////////////////////////////////////////////////////////////////////////////
    // register map, byte addresses
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        REG_CTRL,
        REG_STATUS,
        REG_RESULT,
        REG_COEF,
        REG_ID,
        REG_BASIS,
        REG_OBS,
        REG_NONE
    } region_e;

    localparam logic [11:0] CTRL_ADDR   = 12'h000;  // bit 0 starts a run
    localparam logic [11:0] STATUS_ADDR = 12'h004;  // bit 0 busy, bit 1 done
    localparam logic [11:0] RESULT_ADDR = 12'h008;
    localparam logic [11:0] COEF_BASE   = 12'h040;
    localparam logic [11:0] ID_BASE     = 12'h080;
    localparam logic [11:0] BASIS_BASE  = 12'h400;
    localparam logic [11:0] OBS_BASE    = 12'h800;

endpackage

//--- compile.f
+incdir+.
cost_pkg.sv
axil_pkg.sv
cost_axil_regs.sv
cost_seq.sv
point_gen.sv
proj_unit.sv
residual_acc.sv
cost_top.sv
tb_cost.sv

//--- cost_axil_regs.sv
`timescale 1ns/1ps

module cost_axil_regs #(
    parameter int NUM_ELEMENTS = 4,
    parameter int NUM_POINTS   = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  axil_pkg::aw_t     aw,
    output logic              awready,
    input  axil_pkg::w_t      w,
    output logic              wready,
    output axil_pkg::b_t      b,
    input  logic              bready,
    input  axil_pkg::ar_t     ar,
    output logic              arready,
    output axil_pkg::r_t      r,
    input  logic              rready,
    input  logic              busy,
    input  cost_pkg::data_t   result,
    input  logic              result_valid,
    output logic              start,
    output cost_pkg::mem_wr_t basis_wr,
    output cost_pkg::mem_wr_t obs_wr,
    output cost_pkg::data_t   coef [cost_pkg::NUM_COEF],
    output cost_pkg::data_t   id   [NUM_ELEMENTS]
);

    localparam int COEF_AW = $clog2(cost_pkg::NUM_COEF);
    localparam int ID_AW   = (NUM_ELEMENTS > 1) ? $clog2(NUM_ELEMENTS) : 1;

    axil_pkg::region_e wr_rg;
    axil_pkg::region_e rd_rg;
    logic [11:0]       wr_off;
    logic [11:0]       rd_off;
    logic              wr_fire;
    logic              wr_prot;
    logic              wr_ok;
    logic              rd_fire;
    logic              done_q;
    cost_pkg::data_t   result_q;
    logic [31:0]       rd_data;

    function automatic axil_pkg::region_e decode(input logic [11:0] addr);
        logic [11:0] a;
        a = {addr[11:2], 2'b00};                // byte lanes ignored
        if (a == axil_pkg::CTRL_ADDR) return axil_pkg::REG_CTRL;
        if (a == axil_pkg::STATUS_ADDR) return axil_pkg::REG_STATUS;
        if (a == axil_pkg::RESULT_ADDR) return axil_pkg::REG_RESULT;
        if (a >= axil_pkg::COEF_BASE && a < axil_pkg::COEF_BASE + 12'(4 * cost_pkg::NUM_COEF))
            return axil_pkg::REG_COEF;
        if (a >= axil_pkg::ID_BASE && a < axil_pkg::ID_BASE + 12'(4 * NUM_ELEMENTS))
            return axil_pkg::REG_ID;
        if (a >= axil_pkg::BASIS_BASE &&
            a < axil_pkg::BASIS_BASE + 12'(12 * NUM_POINTS * NUM_ELEMENTS))
            return axil_pkg::REG_BASIS;         // 3 coords x points x elements
        if (a >= axil_pkg::OBS_BASE && a < axil_pkg::OBS_BASE + 12'(8 * NUM_POINTS))
            return axil_pkg::REG_OBS;           // u,v per point
        return axil_pkg::REG_NONE;
    endfunction

    function automatic logic [11:0] word_off(input axil_pkg::region_e rg, input logic [11:0] addr);
        logic [11:0] base;
        case (rg)
            axil_pkg::REG_COEF:  base = axil_pkg::COEF_BASE;
            axil_pkg::REG_ID:    base = axil_pkg::ID_BASE;
            axil_pkg::REG_BASIS: base = axil_pkg::BASIS_BASE;
            axil_pkg::REG_OBS:   base = axil_pkg::OBS_BASE;
            default:             base = '0;
        endcase
        return (addr - base) >> 2;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_rg   = decode(aw.addr);
        wr_off  = word_off(wr_rg, aw.addr);
        rd_rg   = decode(ar.addr);
        rd_off  = word_off(rd_rg, ar.addr);
        wr_fire = aw.valid && w.valid && !b.valid;         // aw and w taken together
        wr_prot = busy && wr_rg inside {axil_pkg::REG_CTRL, axil_pkg::REG_COEF,
                                        axil_pkg::REG_ID, axil_pkg::REG_BASIS,
                                        axil_pkg::REG_OBS};
        wr_ok   = wr_fire && wr_rg != axil_pkg::REG_NONE && !wr_prot;
        rd_fire = ar.valid && !r.valid;
    end

    assign awready  = wr_fire;
    assign wready   = wr_fire;
    assign arready  = !r.valid;                // held response blocks next read
    assign start    = wr_ok && wr_rg == axil_pkg::REG_CTRL && w.data[0];
    assign basis_wr = '{en: wr_ok && wr_rg == axil_pkg::REG_BASIS, idx: wr_off, data: w.data};
    assign obs_wr   = '{en: wr_ok && wr_rg == axil_pkg::REG_OBS, idx: wr_off, data: w.data};

    always_ff @(posedge clk) begin
        if (wr_ok && wr_rg == axil_pkg::REG_COEF) coef[wr_off[COEF_AW-1:0]] <= w.data;
        if (wr_ok && wr_rg == axil_pkg::REG_ID) id[wr_off[ID_AW-1:0]] <= w.data;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            b.valid <= 1'b0;
        end else if (wr_fire) begin
            b.valid <= 1'b1;
            if (wr_rg == axil_pkg::REG_NONE || wr_prot) begin
                b.resp <= axil_pkg::RESP_SLVERR;    // unmapped or locked while busy
            end else begin
                b.resp <= axil_pkg::RESP_OKAY;
            end
        end else if (bready) begin
            b.valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // status, result and read path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            if (start) done_q <= 1'b0;
            else if (result_valid) done_q <= 1'b1;
            if (result_valid) result_q <= result;   // keep last run's cost
        end
    end

    always_comb begin
        case (rd_rg)
            axil_pkg::REG_STATUS: rd_data = {30'd0, done_q, busy};
            axil_pkg::REG_RESULT: rd_data = result_q;
            axil_pkg::REG_COEF:   rd_data = coef[rd_off[COEF_AW-1:0]];
            axil_pkg::REG_ID:     rd_data = id[rd_off[ID_AW-1:0]];
            default:              rd_data = '0;    // ctrl, memories, unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            r.valid <= 1'b0;
        end else if (rd_fire) begin
            r.valid <= 1'b1;
            r.data  <= rd_data;
            if (rd_rg == axil_pkg::REG_NONE) r.resp <= axil_pkg::RESP_SLVERR;
            else r.resp <= axil_pkg::RESP_OKAY;
        end else if (rready) begin
            r.valid <= 1'b0;
        end
    end

endmodule

//--- cost_pkg.sv
package cost_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // arithmetic and geometry
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [31:0] data_t;         // all math wraps mod 2^32

    localparam int NUM_COEF = 8;                // u row 0..2, v row 3..5, tu 6, tv 7

    typedef struct packed {
        data_t x;
        data_t y;
        data_t z;
    } point_t;                                  // model point, 96 bits

    typedef struct packed {
        data_t u;
        data_t v;
    } pix_t;                                    // image position, projected or observed

    ////////////////////////////////////////////////////////////////////////////
    // pipeline control
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       valid;
        logic       first;                      // first point of a run
        logic       last;                       // last point of a run
        logic [7:0] idx;                        // point index
    } tag_t;

    typedef struct packed {
        logic        en;
        logic [11:0] idx;                       // word index inside the target memory
        data_t       data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_e;

endpackage

//--- cost_seq.sv
`timescale 1ns/1ps

module cost_seq #(
    parameter int NUM_POINTS = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           result_valid,
    output logic           busy,
    output cost_pkg::tag_t seq_tag
);

    cost_pkg::seq_state_e state;
    logic [7:0]           cnt;                  // point being issued

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= cost_pkg::SEQ_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                cost_pkg::SEQ_IDLE: begin
                    cnt <= '0;
                    if (start) state <= cost_pkg::SEQ_ISSUE;
                end
                cost_pkg::SEQ_ISSUE: begin
                    cnt <= cnt + 8'd1;          // one point per cycle
                    if (cnt == 8'(NUM_POINTS - 1)) state <= cost_pkg::SEQ_DRAIN;
                end
                cost_pkg::SEQ_DRAIN: begin
                    if (result_valid) state <= cost_pkg::SEQ_IDLE;  // pipeline empty
                end
                default: state <= cost_pkg::SEQ_IDLE;
            endcase
        end
    end

    // tag is decoded straight from state and counter
    always_comb begin
        seq_tag.valid = state == cost_pkg::SEQ_ISSUE;
        seq_tag.first = cnt == 8'd0;
        seq_tag.last  = cnt == 8'(NUM_POINTS - 1);
        seq_tag.idx   = cnt;
    end

    assign busy = state != cost_pkg::SEQ_IDLE;

endmodule

//--- cost_top.sv
`timescale 1ns/1ps

module cost_top #(
    parameter int NUM_ELEMENTS = 4,
    parameter int NUM_POINTS   = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  axil_pkg::aw_t aw,
    output logic          awready,
    input  axil_pkg::w_t  w,
    output logic          wready,
    output axil_pkg::b_t  b,
    input  logic          bready,
    input  axil_pkg::ar_t ar,
    output logic          arready,
    output axil_pkg::r_t  r,
    input  logic          rready
);

    logic              start;
    logic              busy;
    logic              result_valid;
    cost_pkg::data_t   result;
    cost_pkg::mem_wr_t basis_wr;
    cost_pkg::mem_wr_t obs_wr;
    cost_pkg::data_t   coef [cost_pkg::NUM_COEF];
    cost_pkg::data_t   id   [NUM_ELEMENTS];
    cost_pkg::tag_t    seq_tag;
    cost_pkg::tag_t    pg_tag;              // point_gen to proj_unit
    cost_pkg::point_t  pg_point;
    cost_pkg::tag_t    pj_tag;              // proj_unit to residual_acc
    cost_pkg::pix_t    pj_pix;

    ////////////////////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////////////////////

    cost_axil_regs #(.NUM_ELEMENTS(NUM_ELEMENTS), .NUM_POINTS(NUM_POINTS)) u_regs (
        .clk(clk), .rst(rst),
        .aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
        .ar(ar), .arready(arready), .r(r), .rready(rready),
        .busy(busy), .result(result), .result_valid(result_valid), .start(start),
        .basis_wr(basis_wr), .obs_wr(obs_wr), .coef(coef), .id(id)
    );

    cost_seq #(.NUM_POINTS(NUM_POINTS)) u_seq (
        .clk(clk), .rst(rst), .start(start), .result_valid(result_valid),
        .busy(busy), .seq_tag(seq_tag)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath, six stages deep
    ////////////////////////////////////////////////////////////////////////////

    point_gen #(.NUM_ELEMENTS(NUM_ELEMENTS), .NUM_POINTS(NUM_POINTS)) u_point_gen (
        .clk(clk), .rst(rst), .basis_wr(basis_wr), .id(id),
        .tag_in(seq_tag), .point(pg_point), .tag_out(pg_tag)
    );

    proj_unit u_proj (
        .clk(clk), .rst(rst), .coef(coef), .point(pg_point),
        .tag_in(pg_tag), .pix(pj_pix), .tag_out(pj_tag)
    );

    residual_acc #(.NUM_POINTS(NUM_POINTS)) u_residual (
        .clk(clk), .rst(rst), .obs_wr(obs_wr), .pix(pj_pix), .tag_in(pj_tag),
        .result(result), .result_valid(result_valid)
    );

endmodule

//--- point_gen.sv
`timescale 1ns/1ps

module point_gen #(
    parameter int NUM_ELEMENTS = 4,
    parameter int NUM_POINTS   = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  cost_pkg::mem_wr_t basis_wr,
    input  cost_pkg::data_t   id [NUM_ELEMENTS],
    input  cost_pkg::tag_t    tag_in,
    output cost_pkg::point_t  point,
    output cost_pkg::tag_t    tag_out
);

    localparam int ROW_WORDS = NUM_POINTS * NUM_ELEMENTS;  // words per coordinate
    localparam int ROW_AW    = $clog2(ROW_WORDS);

    cost_pkg::tag_t tag_q;

    ////////////////////////////////////////////////////////////////////////////
    // one basis row and one dot product per coordinate
    ////////////////////////////////////////////////////////////////////////////

    for (genvar c = 0; c < 3; c++) begin : g_row
        cost_pkg::data_t mem    [ROW_WORDS];
        cost_pkg::data_t prod_q [NUM_ELEMENTS];
        cost_pkg::data_t sum_q;
        logic [11:0]     wr_loc;
        logic            wr_hit;

        assign wr_loc = basis_wr.idx - 12'(c * ROW_WORDS);
        assign wr_hit = basis_wr.en && basis_wr.idx >= 12'(c * ROW_WORDS) &&
                        wr_loc < 12'(ROW_WORDS);

        always_ff @(posedge clk) begin
            if (wr_hit) mem[wr_loc[ROW_AW-1:0]] <= basis_wr.data;
        end

        always_ff @(posedge clk) begin          // stage 1, basis x id
            for (int k = 0; k < NUM_ELEMENTS; k++) begin
                prod_q[k] <= mem[ROW_AW'(tag_in.idx * NUM_ELEMENTS + k)] * id[k];
            end
        end

        always_ff @(posedge clk) begin          // stage 2, balanced adder tree
            cost_pkg::data_t node [2*NUM_ELEMENTS-1];
            for (int k = 0; k < NUM_ELEMENTS; k++) begin
                node[NUM_ELEMENTS-1+k] = prod_q[k];     // leaves
            end
            for (int n = NUM_ELEMENTS - 2; n >= 0; n--) begin
                node[n] = node[2*n+1] + node[2*n+2];
            end
            sum_q <= node[0];                   // root
        end
    end

    assign point = '{x: g_row[0].sum_q, y: g_row[1].sum_q, z: g_row[2].sum_q};

    always_ff @(posedge clk) begin
        if (!rst) begin
            tag_q   <= '0;
            tag_out <= '0;
        end else begin
            tag_q   <= tag_in;
            tag_out <= tag_q;                   // lines up with point
        end
    end

endmodule

//--- proj_unit.sv
`timescale 1ns/1ps

module proj_unit (
    input  logic             clk,
    input  logic             rst,
    input  cost_pkg::data_t  coef [cost_pkg::NUM_COEF],
    input  cost_pkg::point_t point,
    input  cost_pkg::tag_t   tag_in,
    output cost_pkg::pix_t   pix,
    output cost_pkg::tag_t   tag_out
);

    cost_pkg::data_t prod_q [6];                // u row 0..2, v row 3..5
    cost_pkg::tag_t  tag_q;

    always_ff @(posedge clk) begin              // stage 1
        for (int r = 0; r < 2; r++) begin
            prod_q[3*r]   <= coef[3*r]   * point.x;
            prod_q[3*r+1] <= coef[3*r+1] * point.y;
            prod_q[3*r+2] <= coef[3*r+2] * point.z;
        end
    end

    always_ff @(posedge clk) begin              // stage 2, row sums plus translation
        pix.u <= prod_q[0] + prod_q[1] + prod_q[2] + coef[6];
        pix.v <= prod_q[3] + prod_q[4] + prod_q[5] + coef[7];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tag_q   <= '0;
            tag_out <= '0;
        end else begin
            tag_q   <= tag_in;
            tag_out <= tag_q;
        end
    end

endmodule

//--- residual_acc.sv
`timescale 1ns/1ps

module residual_acc #(
    parameter int NUM_POINTS = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  cost_pkg::mem_wr_t obs_wr,
    input  cost_pkg::pix_t    pix,
    input  cost_pkg::tag_t    tag_in,
    output cost_pkg::data_t   result,
    output logic              result_valid
);

    localparam int OBS_WORDS = 2 * NUM_POINTS;  // u at even, v at odd words
    localparam int OBS_AW    = $clog2(OBS_WORDS);

    cost_pkg::data_t obs_mem [OBS_WORDS];
    cost_pkg::data_t du;
    cost_pkg::data_t dv;
    cost_pkg::data_t sq_q [2];
    cost_pkg::data_t acc;
    cost_pkg::tag_t  tag_q;
    logic            last_q;                    // acc holds the final sum

    always_ff @(posedge clk) begin
        if (obs_wr.en && obs_wr.idx < 12'(OBS_WORDS)) obs_mem[OBS_AW'(obs_wr.idx)] <= obs_wr.data;
    end

    assign du = pix.u - obs_mem[OBS_AW'({tag_in.idx, 1'b0})];
    assign dv = pix.v - obs_mem[OBS_AW'({tag_in.idx, 1'b1})];

    always_ff @(posedge clk) begin              // stage 1, squared residuals
        sq_q[0] <= du * du;
        sq_q[1] <= dv * dv;
    end

    always_ff @(posedge clk) begin              // stage 2, accumulate
        if (tag_q.valid) begin
            if (tag_q.first) acc <= sq_q[0] + sq_q[1];     // new run reloads
            else acc <= acc + sq_q[0] + sq_q[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tag_q        <= '0;
            last_q       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            tag_q        <= tag_in;
            last_q       <= tag_q.valid && tag_q.last;
            result_valid <= last_q;             // one-cycle pulse
        end
    end

    assign result = acc;

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_cost -o tb_cost \
    && ./obj_dir/tb_cost | tee /dev/stderr | grep -F "TESTBENCH PASSED" > /dev/null \
    && exit 0 \
    || exit 1

//--- tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int WAIT_LIMIT = 64;                 // cycles before a handshake wait gives up

// aw and w go out together and stay up until the slave takes both
task automatic issue_write(input logic [11:0] addr, input logic [31:0] data);
    int n;
    @(negedge clk);
    aw = '{valid: 1'b1, addr: addr};
    w  = '{valid: 1'b1, data: data};
    n  = 0;
    #1;                                         // combinational ready settles here
    while (!(awready && wready) && n < WAIT_LIMIT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!(awready && wready)) begin
        $display("timeout at %0t ns: write to %03h was never accepted", $time, addr);
        timeouts++;
    end
    @(negedge clk);                             // taken on the rising edge just passed
    aw.valid = 1'b0;
    w.valid  = 1'b0;
endtask

task automatic await_bresp(output axil_pkg::resp_e resp);
    int n;
    n = 0;
    #1;
    while (!b.valid && n < WAIT_LIMIT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!b.valid) begin
        $display("timeout at %0t ns: no write response came back", $time);
        timeouts++;
    end
    resp = b.resp;                              // handshake on the next edge if bready
endtask

task automatic write_word(input logic [11:0] addr, input logic [31:0] data,
                          output axil_pkg::resp_e resp);
    issue_write(addr, data);
    await_bresp(resp);
endtask

task automatic read_word(input logic [11:0] addr, output logic [31:0] data,
                         output axil_pkg::resp_e resp);
    int n;
    @(negedge clk);
    ar = '{valid: 1'b1, addr: addr};
    n  = 0;
    #1;
    while (!arready && n < WAIT_LIMIT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!arready) begin
        $display("timeout at %0t ns: read of %03h was never accepted", $time, addr);
        timeouts++;
    end
    @(negedge clk);
    ar.valid = 1'b0;
    n = 0;
    #1;
    while (!r.valid && n < WAIT_LIMIT) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (!r.valid) begin
        $display("timeout at %0t ns: no read data came back from %03h", $time, addr);
        timeouts++;
    end
    data = r.data;
    resp = r.resp;
endtask

`endif

//--- tb_cost.sv
`timescale 1ns/1ps

module tb_cost;

    localparam int NE         = 4;              // id vector length
    localparam int NP         = 8;              // model points
    localparam int DONE_LIMIT = 100;            // status polls before giving up
    localparam int unsigned SEED = 20;

    logic          clk;
    logic          rst;
    axil_pkg::aw_t aw;
    logic          awready;
    axil_pkg::w_t  w;
    logic          wready;
    axil_pkg::b_t  b;
    logic          bready;
    axil_pkg::ar_t ar;
    logic          arready;
    axil_pkg::r_t  r;
    logic          rready;

    int checks     = 0;
    int mismatches = 0;
    int timeouts   = 0;

    // model copy of everything loaded through the bus
    logic [31:0] coef_m  [cost_pkg::NUM_COEF];
    logic [31:0] id_m    [NE];
    logic [31:0] basis_m [3][NP][NE];           // coordinate, point, element
    logic [31:0] obs_m   [NP][2];               // point, axis (0 is u)

    cost_top #(.NUM_ELEMENTS(NE), .NUM_POINTS(NP)) u_dut (
        .clk(clk), .rst(rst),
        .aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
        .ar(ar), .arready(arready), .r(r), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    `include "tb_axil_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // checks and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic put_word(input logic [11:0] addr, input logic [31:0] data,
                            input axil_pkg::resp_e exp_resp, input string what);
        axil_pkg::resp_e resp;
        write_word(addr, data, resp);
        check_value({what, " resp"}, {30'd0, resp}, {30'd0, exp_resp});
    endtask

    task automatic get_word(input logic [11:0] addr, input logic [31:0] exp_data,
                            input axil_pkg::resp_e exp_resp, input string what);
        logic [31:0]     data;
        axil_pkg::resp_e resp;
        read_word(addr, data, resp);
        check_value({what, " data"}, data, exp_data);
        check_value({what, " resp"}, {30'd0, resp}, {30'd0, exp_resp});
    endtask

    // sum over points of squared projection residuals mod 2^32
    function automatic logic [31:0] model_cost();
        logic [31:0] pt [3];
        logic [31:0] u;
        logic [31:0] v;
        logic [31:0] du;
        logic [31:0] dv;
        logic [31:0] cost;
        cost = '0;
        for (int p = 0; p < NP; p++) begin
            for (int c = 0; c < 3; c++) begin
                pt[c] = '0;
                for (int k = 0; k < NE; k++) begin
                    pt[c] = pt[c] + basis_m[c][p][k] * id_m[k];     // basis times id
                end
            end
            u    = coef_m[0] * pt[0] + coef_m[1] * pt[1] + coef_m[2] * pt[2] + coef_m[6];
            v    = coef_m[3] * pt[0] + coef_m[4] * pt[1] + coef_m[5] * pt[2] + coef_m[7];
            du   = u - obs_m[p][0];
            dv   = v - obs_m[p][1];
            cost = cost + du * du + dv * dv;
        end
        return cost;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_memories();
        for (int i = 0; i < cost_pkg::NUM_COEF; i++) begin
            coef_m[i] = $urandom;
            put_word(axil_pkg::COEF_BASE + 12'(4 * i), coef_m[i], axil_pkg::RESP_OKAY, "coef");
        end
        for (int k = 0; k < NE; k++) begin
            id_m[k] = $urandom;
            put_word(axil_pkg::ID_BASE + 12'(4 * k), id_m[k], axil_pkg::RESP_OKAY, "id");
        end
        for (int c = 0; c < 3; c++) begin
            for (int p = 0; p < NP; p++) begin
                for (int k = 0; k < NE; k++) begin
                    basis_m[c][p][k] = $urandom;
                    put_word(axil_pkg::BASIS_BASE + 12'(4 * ((c * NP + p) * NE + k)),
                             basis_m[c][p][k], axil_pkg::RESP_OKAY, "basis");
                end
            end
        end
        for (int p = 0; p < NP; p++) begin
            for (int a = 0; a < 2; a++) begin
                obs_m[p][a] = $urandom;
                put_word(axil_pkg::OBS_BASE + 12'(4 * (p * 2 + a)), obs_m[p][a],
                         axil_pkg::RESP_OKAY, "obs");
            end
        end
    endtask

    task automatic start_run();
        put_word(axil_pkg::CTRL_ADDR, 32'h1, axil_pkg::RESP_OKAY, "start");
    endtask

    task automatic wait_done();
        logic [31:0]     data;
        axil_pkg::resp_e resp;
        int              n;
        data = '0;
        n    = 0;
        while (!data[1] && n < DONE_LIMIT) begin
            read_word(axil_pkg::STATUS_ADDR, data, resp);
            n++;
        end
        if (!data[1]) begin
            $display("timeout at %0t ns: the run never set done in status", $time);
            timeouts++;
        end
    endtask

    task automatic check_result(input string what);
        get_word(axil_pkg::STATUS_ADDR, 32'h2, axil_pkg::RESP_OKAY, {what, " status"});
        get_word(axil_pkg::RESULT_ADDR, model_cost(), axil_pkg::RESP_OKAY, {what, " result"});
    endtask

    initial begin
        axil_pkg::resp_e held_resp;
        logic [31:0]     held_val;
        logic [31:0]     next_val;
        aw     = '0;
        w      = '0;
        ar     = '0;
        bready = 1'b1;
        rready = 1'b1;
        rst    = 1'b0;                          // reset asserted from time 0
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // idle state after reset
        get_word(axil_pkg::STATUS_ADDR, 32'h0, axil_pkg::RESP_OKAY, "reset status");
        get_word(axil_pkg::RESULT_ADDR, 32'h0, axil_pkg::RESP_OKAY, "reset result");

        load_memories();
        start_run();
        wait_done();
        check_result("run 1");

        // new id and translations with basis and observations kept
        for (int k = 0; k < NE; k++) begin
            id_m[k] = $urandom;
            put_word(axil_pkg::ID_BASE + 12'(4 * k), id_m[k], axil_pkg::RESP_OKAY, "id");
        end
        for (int i = 6; i < 8; i++) begin
            coef_m[i] = $urandom;
            put_word(axil_pkg::COEF_BASE + 12'(4 * i), coef_m[i], axil_pkg::RESP_OKAY, "coef");
        end
        start_run();
        wait_done();
        check_result("run 2");

        // writes while busy bounce off
        start_run();
        get_word(axil_pkg::STATUS_ADDR, 32'h1, axil_pkg::RESP_OKAY, "busy status");
        put_word(axil_pkg::BASIS_BASE, $urandom, axil_pkg::RESP_SLVERR, "basis while busy");
        put_word(axil_pkg::COEF_BASE, $urandom, axil_pkg::RESP_SLVERR, "coef while busy");
        put_word(axil_pkg::CTRL_ADDR, 32'h1, axil_pkg::RESP_SLVERR, "ctrl while busy");
        wait_done();
        check_result("run 3");

        // hole in the map
        put_word(12'h100, $urandom, axil_pkg::RESP_SLVERR, "unmapped write");
        get_word(12'h100, 32'h0, axil_pkg::RESP_SLVERR, "unmapped read");

        // b held by a low bready blocks the next write
        @(negedge clk);
        bready   = 1'b0;
        held_val = $urandom;
        next_val = $urandom;
        issue_write(axil_pkg::COEF_BASE + 12'd4, held_val);
        await_bresp(held_resp);
        check_value("held b resp", {30'd0, held_resp}, {30'd0, axil_pkg::RESP_OKAY});
        @(negedge clk);
        aw = '{valid: 1'b1, addr: axil_pkg::COEF_BASE + 12'd8};    // second write waits
        w  = '{valid: 1'b1, data: next_val};
        repeat (4) begin
            #1;
            check_value("held b valid", {31'd0, b.valid}, 32'h1);
            check_value("held b resp", {30'd0, b.resp}, {30'd0, held_resp});
            check_value("awready while b held", {31'd0, awready}, 32'h0);
            check_value("wready while b held", {31'd0, wready}, 32'h0);
            @(negedge clk);
        end
        bready = 1'b1;
        put_word(axil_pkg::COEF_BASE + 12'd8, next_val, axil_pkg::RESP_OKAY, "write after b");
        get_word(axil_pkg::COEF_BASE + 12'd4, held_val, axil_pkg::RESP_OKAY, "coef 1 readback");
        get_word(axil_pkg::COEF_BASE + 12'd8, next_val, axil_pkg::RESP_OKAY, "coef 2 readback");

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
